// ==== Bender.yml ====
package:
  name: soc_board

sources:
  - files:
      - design/soc_pkg.sv
      - design/mem_if.sv
      - design/reset_pulse_gen.sv
      - design/uart_rx.sv
      - design/uart_tx.sv
      - design/monitor_ctrl.sv
      - design/scratch_mem.sv
      - design/soc_board_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/soc_board_props.sv
      - verif/tb_soc_board.sv

// ==== design/mem_if.sv ====
`timescale 1ns/1ps

interface mem_if;

   logic                          en;
   logic                          we;
   logic [soc_pkg::MEM_ADDR_W-1:0] addr;
   logic [7:0]                    wdata;
   // valid one cycle after a read enable
   logic [7:0]                    rdata;

   modport ctrl(output en, output we, output addr, output wdata, input rdata);

   modport mem(input en, input we, input addr, input wdata, output rdata);

endinterface

// ==== design/monitor_ctrl.sv ====
`timescale 1ns/1ps

module monitor_ctrl (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic [7:0] rx_byte_i,
   input  logic       rx_valid_i,
   input  logic       tx_busy_i,
   output logic [7:0] tx_byte_o,
   output logic       tx_start_o,
   output logic       trap_o,
   mem_if.ctrl        mem
);

   soc_pkg::ctrl_state_t           state_q;
   soc_pkg::ctrl_state_t           state_d;
   logic                           is_write_q;
   logic [soc_pkg::MEM_ADDR_W-1:0] addr_q;
   logic                           opcode_ok;
   logic                           addr_ok;

   assign opcode_ok = (rx_byte_i == soc_pkg::CMD_WRITE) || (rx_byte_i == soc_pkg::CMD_READ);
   assign addr_ok   = rx_byte_i < soc_pkg::MEM_DEPTH;

   always_comb begin
      state_d = state_q;
      case (state_q)
         soc_pkg::ST_IDLE: begin
            if (rx_valid_i) begin
               state_d = opcode_ok ? soc_pkg::ST_ADDR : soc_pkg::ST_TRAP;
            end
         end
         soc_pkg::ST_ADDR: begin
            if (rx_valid_i) begin
               if (!addr_ok) begin
                  state_d = soc_pkg::ST_TRAP;
               end else if (is_write_q) begin
                  state_d = soc_pkg::ST_DATA;
               end else begin
                  state_d = soc_pkg::ST_READ;
               end
            end
         end
         soc_pkg::ST_DATA: begin
            if (rx_valid_i) begin
               state_d = soc_pkg::ST_SEND;
            end
         end
         // one cycle for the registered memory read
         soc_pkg::ST_READ: state_d = soc_pkg::ST_SEND;
         soc_pkg::ST_SEND: begin
            if (!tx_busy_i) begin
               state_d = soc_pkg::ST_IDLE;
            end
         end
         // absorbing until reset
         soc_pkg::ST_TRAP: state_d = soc_pkg::ST_TRAP;
         default: state_d = soc_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q    <= soc_pkg::ST_IDLE;
         is_write_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == soc_pkg::ST_IDLE && rx_valid_i) begin
            is_write_q <= rx_byte_i == soc_pkg::CMD_WRITE;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == soc_pkg::ST_ADDR && rx_valid_i) begin
         addr_q <= rx_byte_i[soc_pkg::MEM_ADDR_W-1:0];
      end
   end

   // write on the data byte, read from the latched address
   assign mem.we    = (state_q == soc_pkg::ST_DATA) && rx_valid_i;
   assign mem.en    = mem.we || (state_q == soc_pkg::ST_READ);
   assign mem.addr  = addr_q;
   assign mem.wdata = rx_byte_i;

   assign tx_start_o = (state_q == soc_pkg::ST_SEND) && !tx_busy_i;
   assign tx_byte_o  = is_write_q ? soc_pkg::REPLY_ACK : mem.rdata;
   assign trap_o     = state_q == soc_pkg::ST_TRAP;

endmodule

// ==== design/reset_pulse_gen.sv ====
`timescale 1ns/1ps

module reset_pulse_gen (
   input  logic clk_i,
   input  logic rst_n_i,
   output logic sys_rst_n_o,
   output logic ready_o
);

   logic [soc_pkg::RST_CNT_W-1:0] hold_cnt_q;
   logic                          ready_q;

   // counts edges with board reset high, saturates at RST_HOLD
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         hold_cnt_q <= '0;
         ready_q    <= 1'b0;
      end else begin
         if (hold_cnt_q != soc_pkg::RST_CNT_W'(soc_pkg::RST_HOLD)) begin
            hold_cnt_q <= hold_cnt_q + 1'b1;
         end
         // set on the RST_HOLD-th edge
         if (hold_cnt_q == soc_pkg::RST_CNT_W'(soc_pkg::RST_HOLD - 1)) begin
            ready_q <= 1'b1;
         end
      end
   end

   // internal reset released together with ready
   assign sys_rst_n_o = ready_q;
   assign ready_o     = ready_q;

endmodule

// ==== design/scratch_mem.sv ====
`timescale 1ns/1ps

module scratch_mem (
   input logic clk_i,
   input logic rst_n_i,
   mem_if.mem  mem
);

   logic [7:0] ram_q [soc_pkg::MEM_DEPTH];
   logic [7:0] rdata_q;

   // contents start at zero, like the board memory after init
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < soc_pkg::MEM_DEPTH; i++) begin
            ram_q[i] <= '0;
         end
         rdata_q <= '0;
      end else if (mem.en) begin
         if (mem.we) begin
            ram_q[mem.addr] <= mem.wdata;
         end else begin
            rdata_q <= ram_q[mem.addr];
         end
      end
   end

   assign mem.rdata = rdata_q;

endmodule

// ==== design/soc_board_top.sv ====
`timescale 1ns/1ps

module soc_board_top (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic rxd_i,
   output logic txd_o,
   output logic trap_o,
   output logic ready_o
);

   logic       sys_rst_n;
   logic [7:0] rx_byte;
   logic       rx_valid;
   logic [7:0] tx_byte;
   logic       tx_start;
   logic       tx_busy;

   mem_if mem_bus ();

   // clean fixed-length reset for everything below
   reset_pulse_gen u_reset_pulse_gen (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .sys_rst_n_o(sys_rst_n),
      .ready_o    (ready_o)
   );

   uart_rx u_uart_rx (
      .clk_i     (clk_i),
      .rst_n_i   (sys_rst_n),
      .rxd_i     (rxd_i),
      .rx_byte_o (rx_byte),
      .rx_valid_o(rx_valid)
   );

   uart_tx u_uart_tx (
      .clk_i     (clk_i),
      .rst_n_i   (sys_rst_n),
      .tx_byte_i (tx_byte),
      .tx_start_i(tx_start),
      .txd_o     (txd_o),
      .tx_busy_o (tx_busy)
   );

   monitor_ctrl u_monitor_ctrl (
      .clk_i     (clk_i),
      .rst_n_i   (sys_rst_n),
      .rx_byte_i (rx_byte),
      .rx_valid_i(rx_valid),
      .tx_busy_i (tx_busy),
      .tx_byte_o (tx_byte),
      .tx_start_o(tx_start),
      .trap_o    (trap_o),
      .mem       (mem_bus.ctrl)
   );

   // stands in for external memory
   scratch_mem u_scratch_mem (
      .clk_i  (clk_i),
      .rst_n_i(sys_rst_n),
      .mem    (mem_bus.mem)
   );

endmodule

// ==== design/soc_pkg.sv ====
package soc_pkg;

   // uart bit timing, in clk_i cycles
   localparam int CLKS_PER_BIT = 8;
   localparam int HALF_BIT     = CLKS_PER_BIT / 2;
   localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);
   // start, eight data bits, stop
   localparam int FRAME_BITS   = 10;

   // internal reset length after board reset release
   localparam int RST_HOLD  = 4;
   localparam int RST_CNT_W = $clog2(RST_HOLD + 1);

   // scratch memory geometry
   localparam int MEM_DEPTH  = 16;
   localparam int MEM_ADDR_W = 4;

   // host command bytes
   localparam logic [7:0] CMD_WRITE = 8'h57;
   localparam logic [7:0] CMD_READ  = 8'h52;
   localparam logic [7:0] REPLY_ACK = 8'h2B;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_ADDR,
      ST_DATA,
      ST_READ,
      ST_SEND,
      ST_TRAP
   } ctrl_state_t;

endpackage

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       rxd_i,
   output logic [7:0] rx_byte_o,
   output logic       rx_valid_o
);

   logic                          rxd_meta_q;
   logic                          rxd_sync_q;
   logic                          active_q;
   logic [soc_pkg::BIT_CNT_W-1:0] cnt_q;
   // 0 start, 1..8 data, 9 stop, 10 trailing half bit
   logic [3:0]                    bit_idx_q;
   logic [7:0]                    shift_q;
   logic                          valid_q;

   // two-flop synchronizer, line idles high
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rxd_meta_q <= 1'b1;
         rxd_sync_q <= 1'b1;
      end else begin
         rxd_meta_q <= rxd_i;
         rxd_sync_q <= rxd_meta_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         active_q  <= 1'b0;
         cnt_q     <= '0;
         bit_idx_q <= '0;
         valid_q   <= 1'b0;
      end else begin
         valid_q <= 1'b0;
         if (!active_q) begin
            // falling edge of start bit, first sample at mid-bit
            if (!rxd_sync_q) begin
               active_q  <= 1'b1;
               cnt_q     <= soc_pkg::BIT_CNT_W'(soc_pkg::HALF_BIT - 1);
               bit_idx_q <= '0;
            end
         end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
         end else begin
            cnt_q     <= soc_pkg::BIT_CNT_W'(soc_pkg::CLKS_PER_BIT - 1);
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 4'd0) begin
               // glitch, not a real start bit
               if (rxd_sync_q) begin
                  active_q <= 1'b0;
               end
            end else if (bit_idx_q == 4'd9) begin
               // bad stop bit drops the frame
               if (!rxd_sync_q) begin
                  active_q <= 1'b0;
               end
               cnt_q <= soc_pkg::BIT_CNT_W'(soc_pkg::HALF_BIT - 1);
            end else if (bit_idx_q == 4'd10) begin
               valid_q  <= 1'b1;
               active_q <= 1'b0;
            end
         end
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk_i) begin
      if (active_q && cnt_q == '0 && bit_idx_q >= 4'd1 && bit_idx_q <= 4'd8) begin
         shift_q <= {rxd_sync_q, shift_q[7:1]};
      end
   end

   assign rx_byte_o  = shift_q;
   assign rx_valid_o = valid_q;

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic [7:0] tx_byte_i,
   input  logic       tx_start_i,
   output logic       txd_o,
   output logic       tx_busy_o
);

   logic                          busy_q;
   logic                          txd_q;
   logic [soc_pkg::BIT_CNT_W-1:0] cnt_q;
   logic [3:0]                    bit_idx_q;
   // stop bit on top, data below
   logic [8:0]                    shift_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         busy_q    <= 1'b0;
         txd_q     <= 1'b1;
         cnt_q     <= '0;
         bit_idx_q <= '0;
      end else if (!busy_q) begin
         if (tx_start_i) begin
            // start bit goes out right away
            busy_q    <= 1'b1;
            txd_q     <= 1'b0;
            cnt_q     <= soc_pkg::BIT_CNT_W'(soc_pkg::CLKS_PER_BIT - 1);
            bit_idx_q <= '0;
         end
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 1'b1;
      end else begin
         cnt_q <= soc_pkg::BIT_CNT_W'(soc_pkg::CLKS_PER_BIT - 1);
         if (bit_idx_q == 4'(soc_pkg::FRAME_BITS - 1)) begin
            busy_q <= 1'b0;
            txd_q  <= 1'b1;
         end else begin
            bit_idx_q <= bit_idx_q + 1'b1;
            txd_q     <= shift_q[0];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!busy_q && tx_start_i) begin
         shift_q <= {1'b1, tx_byte_i};
      end else if (busy_q && cnt_q == '0) begin
         shift_q <= {1'b1, shift_q[8:1]};
      end
   end

   assign txd_o     = txd_q;
   assign tx_busy_o = busy_q;

endmodule

// ==== src.f ====
design/soc_pkg.sv
design/mem_if.sv
design/reset_pulse_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/monitor_ctrl.sv
design/scratch_mem.sv
design/soc_board_top.sv
verif/tb_clk_gen.sv
verif/soc_board_props.sv
verif/tb_soc_board.sv

// ==== verif/soc_board_props.sv ====
`timescale 1ns/1ps

module soc_board_props (
   input logic                 clk_i,
   input logic                 rst_n_i,
   input soc_pkg::ctrl_state_t state_i,
   input logic                 trap_i,
   input logic                 mem_we_i,
   input logic                 tx_start_i,
   input logic                 tx_busy_i
);

   int unsigned fail_cnt = 0;

   // trap is sticky until reset
   trap_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) trap_i |=> trap_i)
      else begin
         fail_cnt++;
         $error("trap_o fell without a reset");
      end

   no_write_in_trap_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state_i == soc_pkg::ST_TRAP) |-> !mem_we_i)
      else begin
         fail_cnt++;
         $error("memory write while trapped");
      end

   // start only into an idle transmitter that then reports busy
   start_when_free_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tx_start_i |-> !tx_busy_i ##1 tx_busy_i)
      else begin
         fail_cnt++;
         $error("tx_start while transmitter busy or not taken by the transmitter");
      end

endmodule

bind monitor_ctrl soc_board_props u_soc_board_props (
   .clk_i     (clk_i),
   .rst_n_i   (rst_n_i),
   .state_i   (state_q),
   .trap_i    (trap_o),
   .mem_we_i  (mem.we),
   .tx_start_i(tx_start_o),
   .tx_busy_i (tx_busy_i)
);

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o
);

   // 40 ns period
   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;
   end

endmodule

// ==== verif/tb_soc_board.sv ====
`timescale 1ns/1ps

module tb_soc_board;

   localparam int FRAME_CYCLES = 10 * soc_pkg::CLKS_PER_BIT;
   localparam int REPLY_WAIT   = 2 * FRAME_CYCLES;
   localparam int N_WRITES     = 40;
   // bytes on the link over all tests, a silent window counts as two
   localparam int LINK_BYTES = 3 * soc_pkg::MEM_DEPTH + 4 * N_WRITES
                             + 3 * soc_pkg::MEM_DEPTH + 8 + 5;
   localparam int TIMEOUT_CYCLES = LINK_BYTES * FRAME_CYCLES * 2 + 200;

   logic       clk;
   logic       rst_n;
   logic       rxd;
   logic       txd;
   logic       trap;
   logic       ready;
   logic [7:0] model_mem [soc_pkg::MEM_DEPTH];
   int         err_cnt;
   int         test_cnt;
   int         failed_cnt;
   int         test_err_start;

   tb_clk_gen u_tb_clk_gen (.clk_o(clk));

   soc_board_top u_soc_board_top (
      .clk_i  (clk),
      .rst_n_i(rst_n),
      .rxd_i  (rxd),
      .txd_o  (txd),
      .trap_o (trap),
      .ready_o(ready)
   );

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
         err_cnt++;
      end
   endtask

   task automatic start_test();
      test_cnt++;
      test_err_start = err_cnt;
   endtask

   task automatic end_test(input string name);
      if (err_cnt != test_err_start) begin
         failed_cnt++;
         $display("test %0d %s: failed, %0d errors", test_cnt, name, err_cnt - test_err_start);
      end else begin
         $display("test %0d %s: ok", test_cnt, name);
      end
   endtask

   // 2 cycles of board reset, then ready after RST_HOLD edges
   task automatic apply_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      check_value("ready_o", ready, 1'b0);
      @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 1; i <= soc_pkg::RST_HOLD; i++) begin
         @(posedge clk);
         @(negedge clk);
         check_value("ready_o", ready, i == soc_pkg::RST_HOLD);
      end
      check_value("txd_o", txd, 1'b1);
      check_value("trap_o", trap, 1'b0);
   endtask

   // start bit, eight data bits lsb first, stop bit
   task automatic send_byte(input logic [7:0] data);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         rxd <= frame[i];
         repeat (soc_pkg::CLKS_PER_BIT - 1) @(posedge clk);
      end
   endtask

   task automatic recv_byte(input int max_wait, output logic [7:0] data, output logic got);
      int waited;
      waited = 0;
      got    = 1'b0;
      data   = '0;
      @(negedge clk);
      while (txd !== 1'b0 && waited < max_wait) begin
         @(negedge clk);
         waited++;
      end
      if (txd === 1'b0) begin
         got = 1'b1;
         // middle of the start bit
         repeat (soc_pkg::CLKS_PER_BIT / 2) @(negedge clk);
         for (int i = 0; i < 8; i++) begin
            repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
            data[i] = txd;
         end
         repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
         if (txd !== 1'b1) begin
            $display("[ERROR] %0t stop bit on txd_o is low", $time);
            err_cnt++;
         end
      end
   endtask

   task automatic expect_reply(input string name, input logic [7:0] expected);
      logic [7:0] data;
      logic       got;
      recv_byte(REPLY_WAIT, data, got);
      if (!got) begin
         $display("[ERROR] %0t no reply on txd_o for %s", $time, name);
         err_cnt++;
      end else begin
         check_value(name, data, expected);
      end
   endtask

   task automatic expect_silence(input string what);
      logic [7:0] data;
      logic       got;
      recv_byte(REPLY_WAIT, data, got);
      if (got) begin
         $display("[ERROR] %0t unexpected reply 0x%02h on txd_o after %s", $time, data, what);
         err_cnt++;
      end
   endtask

   task automatic do_write(input logic [7:0] addr, input logic [7:0] data);
      send_byte(soc_pkg::CMD_WRITE);
      send_byte(addr);
      send_byte(data);
      expect_reply($sformatf("txd_o ack of write 0x%0h", addr), soc_pkg::REPLY_ACK);
      model_mem[addr] = data;
   endtask

   task automatic do_read(input logic [7:0] addr, input logic [7:0] expected);
      send_byte(soc_pkg::CMD_READ);
      send_byte(addr);
      expect_reply($sformatf("txd_o data of read 0x%0h", addr), expected);
   endtask

   task automatic wait_for_trap(input int max_wait);
      int waited;
      waited = 0;
      @(negedge clk);
      while (trap !== 1'b1 && waited < max_wait) begin
         @(negedge clk);
         waited++;
      end
      check_value("trap_o", trap, 1'b1);
   endtask

   // watchdog sized from the traffic of all tests
   initial begin : watchdog
      int cycle_cnt;
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("run hung waiting for a reply, stopped after %0d cycles", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin : stimulus
      logic [7:0] addr;
      logic [7:0] data;
      logic [7:0] opcode;
      void'($urandom(36));
      rst_n      = 1'b0;
      rxd        = 1'b1;
      err_cnt    = 0;
      test_cnt   = 0;
      failed_cnt = 0;
      for (int i = 0; i < soc_pkg::MEM_DEPTH; i++) begin
         model_mem[i] = 8'h00;
      end

      start_test();
      apply_reset();
      end_test("reset and idle outputs");

      start_test();
      for (int a = 0; a < soc_pkg::MEM_DEPTH; a++) begin
         do_read(8'(a), 8'h00);
      end
      end_test("reads after reset");

      // 40 writes into 16 bytes, so some addresses get overwritten
      start_test();
      for (int i = 0; i < N_WRITES; i++) begin
         addr = 8'($urandom_range(soc_pkg::MEM_DEPTH - 1, 0));
         data = 8'($urandom_range(255, 0));
         do_write(addr, data);
      end
      end_test("random writes");

      start_test();
      for (int a = 0; a < soc_pkg::MEM_DEPTH; a++) begin
         do_read(8'(a), model_mem[a]);
      end
      end_test("read back");

      start_test();
      addr = 8'($urandom_range(255, soc_pkg::MEM_DEPTH));
      send_byte(soc_pkg::CMD_READ);
      send_byte(addr);
      expect_silence("read of illegal address");
      check_value("trap_o", trap, 1'b1);
      send_byte(soc_pkg::CMD_READ);
      send_byte(8'($urandom_range(soc_pkg::MEM_DEPTH - 1, 0)));
      expect_silence("read while trapped");
      check_value("trap_o", trap, 1'b1);
      end_test("illegal address trap");

      start_test();
      apply_reset();
      do begin
         opcode = 8'($urandom_range(255, 0));
      end while (opcode == soc_pkg::CMD_WRITE || opcode == soc_pkg::CMD_READ);
      send_byte(opcode);
      wait_for_trap(FRAME_CYCLES);
      apply_reset();
      for (int i = 0; i < soc_pkg::MEM_DEPTH; i++) begin
         model_mem[i] = 8'h00;
      end
      addr = 8'($urandom_range(soc_pkg::MEM_DEPTH - 1, 0));
      do_read(addr, model_mem[addr]);
      end_test("illegal opcode trap and recovery");

      err_cnt += u_soc_board_top.u_monitor_ctrl.u_soc_board_props.fail_cnt;
      $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d", test_cnt,
               failed_cnt, err_cnt, u_soc_board_top.u_monitor_ctrl.u_soc_board_props.fail_cnt);
      if (err_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
